//--- pusch_dr.f
pusch_dr_pkg.sv
cpri_rx_unpack.sv
dr_beam_combine.sv
dr_ant_power.sv
cpri_tx_pack.sv
pusch_dr_top.sv
pusch_dr_checker.sv
tb_pusch_dr.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the pusch_dr testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_pusch_dr -f pusch_dr.f

out=$(./obj_dir/Vtb_pusch_dr) || true
echo "$out"
echo "$out" | grep -q "^STATUS: PASS$"

//--- tb_pusch_dr.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pusch_dr;

    localparam int LANE = 2;
    localparam int ANT  = 2 * LANE;
    localparam int DW   = LANE * 64;
    localparam int SH   = $clog2(ANT);

    logic          clk = 1'b0;
    logic          rst;
    logic [1:0]    rbg_size;
    logic [1:0]    dr_mode;
    logic [DW-1:0] rx_data;
    logic          rx_vld;
    logic          tx_en;
    logic [63:0]   tx0_data;
    logic          tx0_vld;
    logic [DW-1:0] tx1_data;
    logic          tx1_vld;

    logic [31:0]   rng = 32'd98642;
    int            errs = 0;
    logic [63:0]   exp0[$];
    logic [63:0]   got0[$];
    logic [DW-1:0] exp1[$];
    logic [DW-1:0] got1[$];

    pusch_dr_top #(.LANE(LANE)) dut_i (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_rbg_size     (rbg_size),
        .i_dr_mode      (dr_mode),
        .i_rx_data      (rx_data),
        .i_rx_vld       (rx_vld),
        .i_iq_tx_enable (tx_en),
        .o_tx0_data     (tx0_data),
        .o_tx0_vld      (tx0_vld),
        .o_tx1_data     (tx1_data),
        .o_tx1_vld      (tx1_vld)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // outputs settle after posedge so collect them half a cycle later
    always @(negedge clk) begin
        if (tx0_vld) got0.push_back(tx0_data);
        if (tx1_vld) got1.push_back(tx1_data);
    end

    // ----------------------------------------
    // helpers and reference model
    // ----------------------------------------
    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [15:0] rand_sample();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0:    return 16'h8000;             // full-scale corners
            3'd1:    return 16'h7fff;
            default: return r[31:16];
        endcase
    endfunction

    function automatic int abs_sample(input logic [15:0] s);
        return s[15] ? 65536 - int'(s) : int'(s);
    endfunction

    // beams 0 and 1 are what reaches tx lane 0
    function automatic logic [63:0] beam_lane0(input logic [DW-1:0] w);
        logic [63:0] res;
        int          si;
        int          sq;
        for (int b = 0; b < 2; b++) begin
            si = 0;
            sq = 0;
            for (int a = 0; a < ANT; a++) begin
                if ($countones(b & a) % 2 == 1) begin  // odd parity row entry is -1
                    si -= int'($signed(w[32*a +: 16]));
                    sq -= int'($signed(w[32*a+16 +: 16]));
                end else begin
                    si += int'($signed(w[32*a +: 16]));
                    sq += int'($signed(w[32*a+16 +: 16]));
                end
            end
            res[32*b +: 16]    = 16'(si >>> SH);
            res[32*b+16 +: 16] = 16'(sq >>> SH);
        end
        return res;
    endfunction

    task automatic check(input string name, input logic [DW-1:0] exp,
                         input logic [DW-1:0] act);
        if (exp !== act) begin
            $display("error: %s expected %h got %h", name, exp, act);
            errs++;
        end
    endtask

    // ----------------------------------------
    // stimulus and comparison
    // ----------------------------------------
    task automatic send_pkt(input int len, input logic en);
        logic [DW-1:0] w;
        logic [DW-1:0] hw;
        int            pw[ANT];
        int            cnt;
        int            idx;
        int            glen;
        glen = (rbg_size == 2'd0) ? 4 : (rbg_size == 2'd1) ? 8 : 16;
        cnt  = 0;
        idx  = 0;
        foreach (pw[a]) pw[a] = 0;
        w = {next_rand(), next_rand(), next_rand(), next_rand()};
        @(negedge clk);
        rx_data = w;                               // header rides in lane 0 bits 15..0
        rx_vld  = 1'b1;
        tx_en   = en;
        hw = '0;
        hw[15:0]     = w[15:0];
        hw[DW-1 -: 4] = 4'h1;
        if (en) exp1.push_back(hw);
        for (int i = 0; i < len; i++) begin
            for (int k = 0; k < 2*ANT; k++) w[16*k +: 16] = rand_sample();
            @(negedge clk);
            rx_data = w;
            if (en) exp0.push_back((dr_mode == pusch_dr_pkg::DR_MODE_BEAM) ?
                                   beam_lane0(w) : w[63:0]);
            for (int a = 0; a < ANT; a++) begin
                pw[a] += abs_sample(w[32*a +: 16]) + abs_sample(w[32*a+16 +: 16]);
            end
            cnt++;
            if (cnt == glen || i == len - 1) begin // full group or short tail
                hw = '0;
                for (int a = 0; a < ANT; a++) begin
                    hw[24*a +: 24] = 24'(pw[a]);
                    pw[a] = 0;
                end
                hw[DW-5 -: 8] = 8'(idx);
                hw[DW-1 -: 4] = 4'h2;
                if (en) exp1.push_back(hw);
                idx++;
                cnt = 0;
            end
        end
        @(negedge clk);
        rx_vld = 1'b0;
        @(negedge clk);                            // two idle cycles before the next one
    endtask

    task automatic drain_and_compare(input string tag);
        int t;
        t = 0;
        while ((got0.size() < exp0.size() || got1.size() < exp1.size()) && t < 500) begin
            @(negedge clk);
            t++;
        end
        if (got0.size() < exp0.size() || got1.size() < exp1.size()) begin
            $display("timeout: %s test never produced all of its tx words", tag);
            errs++;
        end else begin
            repeat (4) @(negedge clk);             // room for any stray trailing word
        end
        check({tag, " tx0 word count"}, DW'(exp0.size()), DW'(got0.size()));
        check({tag, " tx1 word count"}, DW'(exp1.size()), DW'(got1.size()));
        for (int i = 0; i < exp0.size() && i < got0.size(); i++) begin
            check({tag, " o_tx0_data"}, DW'(exp0[i]), DW'(got0[i]));
        end
        for (int i = 0; i < exp1.size() && i < got1.size(); i++) begin
            check({tag, " o_tx1_data"}, exp1[i], got1[i]);
        end
        exp0.delete();
        got0.delete();
        exp1.delete();
        got1.delete();
    endtask

    task automatic reset_check();
        rst = 1'b1;
        repeat (8) begin
            @(negedge clk);
            check("o_tx0_vld", '0, DW'(tx0_vld));
            check("o_tx1_vld", '0, DW'(tx1_vld));
        end
        rst = 1'b0;
        repeat (4) begin                           // idle after reset
            @(negedge clk);
            check("o_tx0_vld", '0, DW'(tx0_vld));
            check("o_tx1_vld", '0, DW'(tx1_vld));
        end
    endtask

    initial begin
        rst      = 1'b1;
        rbg_size = pusch_dr_pkg::RBG_16;
        dr_mode  = pusch_dr_pkg::DR_MODE_BYPASS;
        rx_data  = '0;
        rx_vld   = 1'b0;
        tx_en    = 1'b1;
        reset_check();

        send_pkt(20, 1'b1);
        drain_and_compare("bypass");

        dr_mode = pusch_dr_pkg::DR_MODE_BEAM;
        send_pkt(12, 1'b1);
        send_pkt(7, 1'b1);
        drain_and_compare("beam");

        for (int s = 0; s < 3; s++) begin          // RBG_4, RBG_8, RBG_16
            rbg_size = 2'(s);
            send_pkt(16, 1'b1);
            send_pkt(19, 1'b1);
            send_pkt(5, 1'b1);
            drain_and_compare("rbg power");
        end

        send_pkt(10, 1'b0);
        send_pkt(10, 1'b1);
        drain_and_compare("tx enable");

        rbg_size = pusch_dr_pkg::RBG_4;
        send_pkt(6, 1'b1);
        send_pkt(9, 1'b1);
        send_pkt(4, 1'b1);
        drain_and_compare("back to back");

        $display("errors: %0d", errs);
        if (errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pusch_dr_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pusch_dr_checker #(
    parameter int LANE = 2
) (
    input wire                                   i_clk,
    input wire                                   i_rst,
    input wire                                   i_tx0_vld,
    input wire                                   i_tx1_vld,
    input wire  [LANE*pusch_dr_pkg::LANE_W-1:0]  i_tx1_data,
    input pusch_dr_pkg::tx_state_e               i_state
);

    localparam int DW = LANE * pusch_dr_pkg::LANE_W;

    logic [pusch_dr_pkg::TAG_W-1:0] tag;

    assign tag = i_tx1_data[DW-1 -: pusch_dr_pkg::TAG_W];

    quiet_in_reset: assert property (@(posedge i_clk)
        ($past(i_rst) || $past(i_rst, 2)) |-> (!i_tx0_vld && !i_tx1_vld))
        else $error("tx valid during reset or right after it");

    tx1_with_tx0: assert property (@(posedge i_clk) i_tx1_vld |-> i_tx0_vld)
        else $error("tx1 valid without tx0 valid");

    tx1_tag_known: assert property (@(posedge i_clk) i_tx1_vld |->
        (tag == pusch_dr_pkg::TX_TAG_HDR || tag == pusch_dr_pkg::TX_TAG_PWR))
        else $error("tx1 word with unknown tag");

    // send and drop are always separated by idle
    send_not_to_drop: assert property (@(posedge i_clk)
        (i_state == pusch_dr_pkg::TX_SEND) |=> (i_state != pusch_dr_pkg::TX_DROP))
        else $error("packer went from send to drop");

    drop_not_to_send: assert property (@(posedge i_clk)
        (i_state == pusch_dr_pkg::TX_DROP) |=> (i_state != pusch_dr_pkg::TX_SEND))
        else $error("packer went from drop to send");

endmodule

bind pusch_dr_top pusch_dr_checker #(.LANE(LANE)) checker_i (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_tx0_vld  (o_tx0_vld),
    .i_tx1_vld  (o_tx1_vld),
    .i_tx1_data (o_tx1_data),
    .i_state    (tx_pack_i.state)
);

`default_nettype wire

//--- pusch_dr_top.sv
`timescale 1ns/1ps
`default_nettype none

module pusch_dr_top #(
    parameter int LANE = 2                     // 1, 2 or 4
) (
    input  wire                                          i_clk,
    input  wire                                          i_rst,
    input  wire  [1:0]                                   i_rbg_size,
    input  wire  [1:0]                                   i_dr_mode,
    input  wire  [LANE*pusch_dr_pkg::LANE_W-1:0]         i_rx_data,
    input  wire                                          i_rx_vld,
    input  wire                                          i_iq_tx_enable,
    output logic [pusch_dr_pkg::LANE_W-1:0]              o_tx0_data,
    output logic                                         o_tx0_vld,
    output logic [LANE*pusch_dr_pkg::LANE_W-1:0]         o_tx1_data,
    output logic                                         o_tx1_vld
);

    localparam int DW = LANE * pusch_dr_pkg::LANE_W;
    localparam int PW = 2 * LANE * pusch_dr_pkg::PWR_W;

    // ----------------------------------------
    // unpacker outputs
    // ----------------------------------------
    logic [DW-1:0]                       iq_data;
    logic                                iq_vld;
    logic                                iq_last;
    logic                                iq_rbg_end;
    logic [pusch_dr_pkg::PKG_TYPE_W-1:0] hdr_pkg_type;
    logic [pusch_dr_pkg::SLOT_W-1:0]     hdr_slot;
    logic [pusch_dr_pkg::SYMB_W-1:0]     hdr_symb;
    logic                                hdr_cell;

    // ----------------------------------------
    // combiner and power meter outputs
    // ----------------------------------------
    logic [DW-1:0]                       bm_data;
    logic                                bm_vld;
    logic                                bm_last;
    logic                                bm_first;
    logic [PW-1:0]                       pwr_data;
    logic                                pwr_vld;
    logic [pusch_dr_pkg::RBG_IDX_W-1:0]  rbg_idx;

    cpri_rx_unpack #(.LANE(LANE)) rx_unpack_i (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_rx_data      (i_rx_data),
        .i_rx_vld       (i_rx_vld),
        .i_rbg_size     (i_rbg_size),
        .o_iq_data      (iq_data),
        .o_iq_vld       (iq_vld),
        .o_iq_last      (iq_last),
        .o_iq_rbg_end   (iq_rbg_end),
        .o_pkg_type     (hdr_pkg_type),
        .o_slot_idx     (hdr_slot),
        .o_symb_idx     (hdr_symb),
        .o_cell_idx     (hdr_cell)
    );

    dr_beam_combine #(.LANE(LANE)) beam_combine_i (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_dr_mode      (i_dr_mode),
        .i_iq_data      (iq_data),
        .i_iq_vld       (iq_vld),
        .i_iq_last      (iq_last),
        .o_bm_data      (bm_data),
        .o_bm_vld       (bm_vld),
        .o_bm_last      (bm_last),
        .o_bm_first     (bm_first)
    );

    dr_ant_power #(.LANE(LANE)) ant_power_i (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_iq_data      (iq_data),
        .i_iq_vld       (iq_vld),
        .i_iq_rbg_end   (iq_rbg_end),
        .i_iq_last      (iq_last),
        .o_pwr_data     (pwr_data),
        .o_pwr_vld      (pwr_vld),
        .o_rbg_idx      (rbg_idx)
    );

    cpri_tx_pack #(.LANE(LANE)) tx_pack_i (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_iq_tx_enable (i_iq_tx_enable),
        .i_bm_data      (bm_data),
        .i_bm_vld       (bm_vld),
        .i_bm_first     (bm_first),
        .i_bm_last      (bm_last),
        .i_pwr_data     (pwr_data),
        .i_pwr_vld      (pwr_vld),
        .i_rbg_idx      (rbg_idx),
        .i_pkg_type     (hdr_pkg_type),
        .i_slot_idx     (hdr_slot),
        .i_symb_idx     (hdr_symb),
        .i_cell_idx     (hdr_cell),
        .o_tx0_data     (o_tx0_data),
        .o_tx0_vld      (o_tx0_vld),
        .o_tx1_data     (o_tx1_data),
        .o_tx1_vld      (o_tx1_vld)
    );

endmodule

`default_nettype wire

//--- cpri_tx_pack.sv
`timescale 1ns/1ps
`default_nettype none

module cpri_tx_pack #(
    parameter int LANE = 2
) (
    input  wire                                          i_clk,
    input  wire                                          i_rst,
    input  wire                                          i_iq_tx_enable,
    input  wire  [LANE*pusch_dr_pkg::LANE_W-1:0]         i_bm_data,
    input  wire                                          i_bm_vld,
    input  wire                                          i_bm_first,
    input  wire                                          i_bm_last,
    input  wire  [2*LANE*pusch_dr_pkg::PWR_W-1:0]        i_pwr_data,
    input  wire                                          i_pwr_vld,
    input  wire  [pusch_dr_pkg::RBG_IDX_W-1:0]           i_rbg_idx,
    input  wire  [pusch_dr_pkg::PKG_TYPE_W-1:0]          i_pkg_type,
    input  wire  [pusch_dr_pkg::SLOT_W-1:0]              i_slot_idx,
    input  wire  [pusch_dr_pkg::SYMB_W-1:0]              i_symb_idx,
    input  wire                                          i_cell_idx,
    output logic [pusch_dr_pkg::LANE_W-1:0]              o_tx0_data,
    output logic                                         o_tx0_vld,
    output logic [LANE*pusch_dr_pkg::LANE_W-1:0]         o_tx1_data,
    output logic                                         o_tx1_vld
);

    localparam int DW      = LANE * pusch_dr_pkg::LANE_W;
    localparam int PW      = 2 * LANE * pusch_dr_pkg::PWR_W;
    localparam int TAG_LSB = DW - pusch_dr_pkg::TAG_W;
    localparam int IDX_LSB = TAG_LSB - pusch_dr_pkg::RBG_IDX_W;

    pusch_dr_pkg::tx_state_e state;
    pusch_dr_pkg::tx_state_e state_nxt;
    logic                    send_now;         // current beam word goes out
    logic [DW-1:0]           hdr_word;
    logic [DW-1:0]           pwr_word;

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_comb begin
        if (state == pusch_dr_pkg::TX_IDLE) begin
            send_now = i_bm_first && i_iq_tx_enable;   // enable sampled on first word
        end else begin
            send_now = (state == pusch_dr_pkg::TX_SEND);
        end
    end

    always_comb begin
        state_nxt = state;
        if (i_bm_vld) begin
            if (i_bm_last) begin
                state_nxt = pusch_dr_pkg::TX_IDLE;
            end else if (state == pusch_dr_pkg::TX_IDLE && i_bm_first) begin
                state_nxt = i_iq_tx_enable ? pusch_dr_pkg::TX_SEND : pusch_dr_pkg::TX_DROP;
            end
        end
    end

    // ----------------------------------------
    // tx lane 1 words
    // ----------------------------------------
    always_comb begin
        hdr_word = '0;
        hdr_word[pusch_dr_pkg::HDR_PKG_LSB +: pusch_dr_pkg::PKG_TYPE_W] = i_pkg_type;
        hdr_word[pusch_dr_pkg::HDR_SLOT_LSB +: pusch_dr_pkg::SLOT_W]    = i_slot_idx;
        hdr_word[pusch_dr_pkg::HDR_SYMB_LSB +: pusch_dr_pkg::SYMB_W]    = i_symb_idx;
        hdr_word[pusch_dr_pkg::HDR_CELL_BIT]                            = i_cell_idx;
        hdr_word[TAG_LSB +: pusch_dr_pkg::TAG_W] = pusch_dr_pkg::TX_TAG_HDR;

        pwr_word = '0;
        pwr_word[PW-1:0]                             = i_pwr_data;
        pwr_word[IDX_LSB +: pusch_dr_pkg::RBG_IDX_W] = i_rbg_idx;
        pwr_word[TAG_LSB +: pusch_dr_pkg::TAG_W]     = pusch_dr_pkg::TX_TAG_PWR;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state     <= pusch_dr_pkg::TX_IDLE;
            o_tx0_vld <= 1'b0;
            o_tx1_vld <= 1'b0;
        end else begin
            state     <= state_nxt;
            o_tx0_vld <= i_bm_vld && send_now;
            o_tx1_vld <= i_bm_vld && send_now && (i_bm_first || i_pwr_vld);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_bm_vld && send_now) begin
            o_tx0_data <= i_bm_data[pusch_dr_pkg::LANE_W-1:0];
            o_tx1_data <= i_bm_first ? hdr_word : pwr_word;    // header wins a tie
        end
    end

endmodule

`default_nettype wire

//--- dr_ant_power.sv
`timescale 1ns/1ps
`default_nettype none

module dr_ant_power #(
    parameter int LANE = 2
) (
    input  wire                                          i_clk,
    input  wire                                          i_rst,
    input  wire  [LANE*pusch_dr_pkg::LANE_W-1:0]         i_iq_data,
    input  wire                                          i_iq_vld,
    input  wire                                          i_iq_rbg_end,
    input  wire                                          i_iq_last,
    output logic [2*LANE*pusch_dr_pkg::PWR_W-1:0]        o_pwr_data,
    output logic                                         o_pwr_vld,
    output logic [pusch_dr_pkg::RBG_IDX_W-1:0]           o_rbg_idx
);

    localparam int ANT   = 2 * LANE;
    localparam int IQ_W  = pusch_dr_pkg::IQ_W;
    localparam int PWR_W = pusch_dr_pkg::PWR_W;
    localparam int ANT_W = pusch_dr_pkg::ANT_W;

    logic [PWR_W-1:0]                   acc      [ANT];
    logic [PWR_W-1:0]                   acc_next [ANT];
    logic [pusch_dr_pkg::RBG_IDX_W-1:0] rbg_cnt;   // RBG index within packet

    // magnitude of -32768 comes out as 32768
    function automatic logic [PWR_W-1:0] mag(input logic [IQ_W-1:0] x);
        logic [IQ_W:0] ext;
        logic [IQ_W:0] abs_v;
        ext   = {x[IQ_W-1], x};
        abs_v = ext[IQ_W] ? -ext : ext;
        return PWR_W'(abs_v);
    endfunction

    always_comb begin
        for (int a = 0; a < ANT; a++) begin
            acc_next[a] = acc[a] + mag(i_iq_data[a*ANT_W +: IQ_W])
                                 + mag(i_iq_data[a*ANT_W+IQ_W +: IQ_W]);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pwr_vld <= 1'b0;
            rbg_cnt   <= '0;
            for (int a = 0; a < ANT; a++) begin
                acc[a] <= '0;
            end
        end else begin
            o_pwr_vld <= i_iq_vld && i_iq_rbg_end;
            if (i_iq_vld) begin
                for (int a = 0; a < ANT; a++) begin
                    acc[a] <= i_iq_rbg_end ? '0 : acc_next[a];  // restart per RBG
                end
                if (i_iq_rbg_end) begin
                    rbg_cnt <= i_iq_last ? '0 : rbg_cnt + 1'b1;
                end
            end
        end
    end

    // sums include the closing word
    always_ff @(posedge i_clk) begin
        if (i_iq_vld && i_iq_rbg_end) begin
            o_rbg_idx <= rbg_cnt;
            for (int a = 0; a < ANT; a++) begin
                o_pwr_data[a*PWR_W +: PWR_W] <= acc_next[a];
            end
        end
    end

endmodule

`default_nettype wire

//--- dr_beam_combine.sv
`timescale 1ns/1ps
`default_nettype none

module dr_beam_combine #(
    parameter int LANE = 2
) (
    input  wire                                          i_clk,
    input  wire                                          i_rst,
    input  wire  [1:0]                                   i_dr_mode,
    input  wire  [LANE*pusch_dr_pkg::LANE_W-1:0]         i_iq_data,
    input  wire                                          i_iq_vld,
    input  wire                                          i_iq_last,
    output logic [LANE*pusch_dr_pkg::LANE_W-1:0]         o_bm_data,
    output logic                                         o_bm_vld,
    output logic                                         o_bm_last,
    output logic                                         o_bm_first
);

    localparam int ANT   = 2 * LANE;
    localparam int DW    = LANE * pusch_dr_pkg::LANE_W;
    localparam int IQ_W  = pusch_dr_pkg::IQ_W;
    localparam int ANT_W = pusch_dr_pkg::ANT_W;
    localparam int SH    = $clog2(ANT);        // scale back to 16 bits
    localparam int SW    = IQ_W + SH;          // full sum width

    logic [DW-1:0] beam_data;
    logic          first_pend;                 // next word opens a packet

    // Hadamard row b, column a is negative when b&a has odd parity
    always_comb begin
        logic signed [SW-1:0]   sum_i;
        logic signed [SW-1:0]   sum_q;
        logic signed [IQ_W-1:0] smp_i;
        logic signed [IQ_W-1:0] smp_q;
        beam_data = '0;
        for (int b = 0; b < ANT; b++) begin
            sum_i = '0;
            sum_q = '0;
            for (int a = 0; a < ANT; a++) begin
                smp_i = i_iq_data[a*ANT_W +: IQ_W];
                smp_q = i_iq_data[a*ANT_W+IQ_W +: IQ_W];
                if (^(b & a)) begin
                    sum_i = sum_i - smp_i;
                    sum_q = sum_q - smp_q;
                end else begin
                    sum_i = sum_i + smp_i;
                    sum_q = sum_q + smp_q;
                end
            end
            beam_data[b*ANT_W +: IQ_W]      = IQ_W'(sum_i >>> SH);
            beam_data[b*ANT_W+IQ_W +: IQ_W] = IQ_W'(sum_q >>> SH);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_bm_vld   <= 1'b0;
            o_bm_last  <= 1'b0;
            o_bm_first <= 1'b0;
            first_pend <= 1'b1;
        end else begin
            o_bm_vld   <= i_iq_vld;
            o_bm_last  <= i_iq_vld && i_iq_last;
            o_bm_first <= i_iq_vld && first_pend;
            if (i_iq_vld) begin
                first_pend <= i_iq_last;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_iq_vld) begin
            o_bm_data <= (i_dr_mode == pusch_dr_pkg::DR_MODE_BEAM) ? beam_data : i_iq_data;
        end
    end

endmodule

`default_nettype wire

//--- cpri_rx_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module cpri_rx_unpack #(
    parameter int LANE = 2
) (
    input  wire                                          i_clk,
    input  wire                                          i_rst,
    input  wire  [LANE*pusch_dr_pkg::LANE_W-1:0]         i_rx_data,
    input  wire                                          i_rx_vld,
    input  wire  [1:0]                                   i_rbg_size,
    output logic [LANE*pusch_dr_pkg::LANE_W-1:0]         o_iq_data,
    output logic                                         o_iq_vld,
    output logic                                         o_iq_last,
    output logic                                         o_iq_rbg_end,
    output logic [pusch_dr_pkg::PKG_TYPE_W-1:0]          o_pkg_type,
    output logic [pusch_dr_pkg::SLOT_W-1:0]              o_slot_idx,
    output logic [pusch_dr_pkg::SYMB_W-1:0]              o_symb_idx,
    output logic                                         o_cell_idx
);

    localparam int DW = LANE * pusch_dr_pkg::LANE_W;

    logic          in_pkt;                     // last cycle was inside a packet
    logic          hold_vld;                   // one IQ word waiting in hold
    logic [DW-1:0] hold_data;
    logic [3:0]    rbg_cnt;                    // words so far in this RBG
    logic [4:0]    rbg_len;
    logic          rbg_end;

    always_comb begin
        case (i_rbg_size)
            pusch_dr_pkg::RBG_4: rbg_len = 5'd4;
            pusch_dr_pkg::RBG_8: rbg_len = 5'd8;
            default:             rbg_len = 5'd16;
        endcase
    end

    // held word closes an RBG when the count is full or the packet ends
    assign rbg_end = !i_rx_vld || ({1'b0, rbg_cnt} + 5'd1 == rbg_len);

    // ----------------------------------------
    // control
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            in_pkt       <= 1'b0;
            hold_vld     <= 1'b0;
            rbg_cnt      <= '0;
            o_iq_vld     <= 1'b0;
            o_iq_last    <= 1'b0;
            o_iq_rbg_end <= 1'b0;
        end else begin
            in_pkt       <= i_rx_vld;
            hold_vld     <= i_rx_vld && in_pkt;    // header word never enters hold
            o_iq_vld     <= hold_vld;
            o_iq_last    <= hold_vld && !i_rx_vld;
            o_iq_rbg_end <= hold_vld && rbg_end;
            if (hold_vld) begin
                rbg_cnt <= rbg_end ? 4'd0 : rbg_cnt + 4'd1;
            end
        end
    end

    // ----------------------------------------
    // payload and header fields
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rx_vld && in_pkt) begin
            hold_data <= i_rx_data;
        end
        if (hold_vld) begin
            o_iq_data <= hold_data;
        end
        if (i_rx_vld && !in_pkt) begin     // first word after idle is the header
            o_pkg_type <= i_rx_data[pusch_dr_pkg::HDR_PKG_LSB +: pusch_dr_pkg::PKG_TYPE_W];
            o_slot_idx <= i_rx_data[pusch_dr_pkg::HDR_SLOT_LSB +: pusch_dr_pkg::SLOT_W];
            o_symb_idx <= i_rx_data[pusch_dr_pkg::HDR_SYMB_LSB +: pusch_dr_pkg::SYMB_W];
            o_cell_idx <= i_rx_data[pusch_dr_pkg::HDR_CELL_BIT];
        end
    end

endmodule

`default_nettype wire

//--- pusch_dr_pkg.sv
`default_nettype none

package pusch_dr_pkg;

    // ----------------------------------------
    // field widths
    // ----------------------------------------
    localparam int IQ_W       = 16;
    localparam int PWR_W      = 24;            // 16 REs of |I|+|Q| fit
    localparam int PKG_TYPE_W = 4;
    localparam int SLOT_W     = 7;
    localparam int SYMB_W     = 4;
    localparam int RBG_IDX_W  = 8;
    localparam int TAG_W      = 4;             // top bits of every tx1 word
    localparam int LANE_W     = 64;            // bits per lane
    localparam int ANT_W      = 2 * IQ_W;      // one antenna or beam, I low, Q high

    // header bit positions, rx lane 0 and tx lane 1 share them
    localparam int HDR_PKG_LSB  = 0;
    localparam int HDR_SLOT_LSB = 4;
    localparam int HDR_SYMB_LSB = 11;
    localparam int HDR_CELL_BIT = 15;

    // ----------------------------------------
    // enums
    // ----------------------------------------
    typedef enum logic [1:0] {
        DR_MODE_BYPASS = 2'd0,
        DR_MODE_BEAM   = 2'd1                  // codes 2 and 3 act as bypass
    } dr_mode_e;

    typedef enum logic [1:0] {
        RBG_4  = 2'd0,
        RBG_8  = 2'd1,
        RBG_16 = 2'd2                          // code 3 acts as RBG_16
    } rbg_size_e;

    typedef enum logic [3:0] {
        TX_TAG_HDR = 4'd1,
        TX_TAG_PWR = 4'd2
    } tx_tag_e;

    typedef enum logic [1:0] {
        TX_IDLE = 2'd0,
        TX_SEND = 2'd1,
        TX_DROP = 2'd2
    } tx_state_e;

endpackage

`default_nettype wire
